//--- dv/ee_slave_model.sv
`default_nettype none

`include "eeprom_defines.svh"

module ee_slave_model
(
    input  wire logic            CLK,
    input  wire logic            RESET,
    input  wire logic            scl,
    input  wire logic            sda,
    input  wire logic            nack_inject,
    output logic                 pull,          // open-drain pull on SDA
    output logic                 in_txn,
    output logic                 rstart_seen,
    output logic                 mst_nack,
    output logic                 proto_err,
    output int                   stop_count,
    output eeprom_pkg::ee_data_t ctrl_w,
    output eeprom_pkg::ee_data_t ctrl_r,
    output eeprom_pkg::ee_addr_t addr_seen,
    output eeprom_pkg::ee_data_t data_seen
);

    timeunit 1ns;
    timeprecision 1ps;

    eeprom_pkg::ee_data_t mem [0:(1 << `EE_ADDR_W) - 1];
    eeprom_pkg::ee_data_t sh;
    eeprom_pkg::ee_data_t tx;
    logic                 prev_scl;
    logic                 prev_sda;
    logic [3:0]           bitn;      // rising edges in the current byte
    int                   byte_idx;
    logic                 seg;       // set after the repeated start
    logic                 sending;
    logic                 ack_pend;
    logic                 nack_lat;
    logic                 wr_pend;

    task automatic flag_error(string what);
        $display("slave model: %s", what);
        proto_err = 1'b1;
    endtask

    // eighth data bit is in, decide the acknowledge
    task automatic take_byte();
        ack_pend = 1'b1;
        case (byte_idx)
            0:
            begin
                if (seg)
                    ctrl_r = sh;
                else
                    ctrl_w = sh;
                ack_pend = (sh[7:4] == `EE_DEV_CODE) && !(nack_lat && !seg);
            end
            1:
            begin
                addr_seen = {ctrl_w[3:1], sh};
            end
            2:
            begin
                data_seen = sh;
                wr_pend   = 1'b1;
            end
            default:
                ack_pend = 1'b0;    // no page writes
        endcase
    endtask

    always @(negedge CLK)
    begin
        if (RESET)
        begin
            mem         = '{default: 8'hFF};   // erased part
            pull        = 1'b0;
            in_txn      = 1'b0;
            rstart_seen = 1'b0;
            mst_nack    = 1'b0;
            proto_err   = 1'b0;
            stop_count  = 0;
            ctrl_w      = '0;
            ctrl_r      = '0;
            addr_seen   = '0;
            data_seen   = '0;
            sh          = '0;
            tx          = '0;
            prev_scl    = 1'b1;
            prev_sda    = 1'b1;
            bitn        = 4'd0;
            byte_idx    = 0;
            seg         = 1'b0;
            sending     = 1'b0;
            ack_pend    = 1'b0;
            nack_lat    = 1'b0;
            wr_pend     = 1'b0;
        end
        else
        begin
            if (prev_scl && scl && prev_sda && !sda)
            begin
                if (in_txn && (bitn != 4'd1 || seg))
                    flag_error("start inside a byte or a second repeated start");
                if (!in_txn)
                begin
                    nack_lat = nack_inject;
                    mst_nack = 1'b0;
                    wr_pend  = 1'b0;
                end
                seg         = in_txn;
                rstart_seen = in_txn;
                in_txn      = 1'b1;
                bitn        = 4'd0;
                byte_idx    = 0;
                sending     = 1'b0;
                ack_pend    = 1'b0;
            end
            else if (prev_scl && scl && !prev_sda && sda)
            begin
                if (!in_txn || bitn != 4'd1)
                    flag_error("stop outside a transaction or inside a byte");
                if (wr_pend)
                    mem[addr_seen] = data_seen;    // part commits on stop
                wr_pend    = 1'b0;
                in_txn     = 1'b0;
                stop_count = stop_count + 1;
            end
            else if (in_txn && !prev_scl && scl)
            begin
                if (bitn != 4'd8)
                begin
                    sh   = {sh[6:0], sda};
                    bitn = bitn + 4'd1;
                    if (bitn == 4'd8 && !sending)
                        take_byte();
                end
                else
                begin
                    if (sending)
                        mst_nack = sda;            // high means master NACK
                    sending  = !sending && ack_pend && seg && byte_idx == 0 && ctrl_r[0];
                    byte_idx = byte_idx + 1;
                    bitn     = 4'd0;
                    tx       = mem[addr_seen];
                end
            end
            else if (in_txn && prev_scl && !scl)
            begin
                // slave only moves SDA after SCL falls
                if (sending)
                    pull = (bitn != 4'd8) && !tx[3'(7 - bitn)];
                else
                    pull = (bitn == 4'd8) && ack_pend;
            end
            prev_scl = scl;
            prev_sda = sda;
        end
    end

endmodule

`default_nettype wire

//--- dv/eeprom_ctrl_tb.sv
`default_nettype none

`include "eeprom_defines.svh"

module eeprom_ctrl_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_TXN   = 200;
    localparam int MAX_CYC = N_TXN * 400;
    localparam eeprom_pkg::ee_addr_t BASE_ADDR = 11'h5E0;   // 32-byte window

    logic                 CLK;
    logic                 RESET;
    logic                 wr;
    logic                 rd;
    eeprom_pkg::ee_addr_t addr;
    eeprom_pkg::ee_data_t wr_data;
    eeprom_pkg::ee_data_t rd_data;
    logic                 busy;
    logic                 done;
    logic                 nack;
    logic                 scl;
    logic                 sda_oe;
    logic                 sda_in;
    logic                 pull;
    logic                 nack_inj;
    logic                 in_txn;
    logic                 rstart_seen;
    logic                 mst_nack;
    logic                 proto_err;
    int                   stop_count;
    eeprom_pkg::ee_data_t ctrl_w;
    eeprom_pkg::ee_data_t ctrl_r;
    eeprom_pkg::ee_addr_t addr_seen;
    eeprom_pkg::ee_data_t data_seen;
    eeprom_pkg::ee_data_t ref_mem [eeprom_pkg::ee_addr_t];
    int                   cycles = 0;

    assign sda_in = ~sda_oe & ~pull;   // wired-AND line

    eeprom_ctrl UUT
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .busy    (busy),
        .done    (done),
        .nack    (nack),
        .scl     (scl),
        .sda_oe  (sda_oe),
        .sda_in  (sda_in)
    );

    ee_slave_model u_slave
    (
        .CLK         (CLK),
        .RESET       (RESET),
        .scl         (scl),
        .sda         (sda_in),
        .nack_inject (nack_inj),
        .pull        (pull),
        .in_txn      (in_txn),
        .rstart_seen (rstart_seen),
        .mst_nack    (mst_nack),
        .proto_err   (proto_err),
        .stop_count  (stop_count),
        .ctrl_w      (ctrl_w),
        .ctrl_r      (ctrl_r),
        .addr_seen   (addr_seen),
        .data_seen   (data_seen)
    );

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "run stopped at cycle %0d", cycles);
    endtask

    always @(posedge CLK)
    begin
        cycles = cycles + 1;
        if (cycles > MAX_CYC)
            abort_run("timeout: the run did not finish within the cycle limit");
        else if (proto_err === 1'b1)
            abort_run("the slave model saw a bus protocol violation");
    end

    task automatic wait_cycle();
        @(posedge CLK);
        #2;
    endtask

    task automatic check_data(string name, eeprom_pkg::ee_data_t got,
                              eeprom_pkg::ee_data_t exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_addr(string name, eeprom_pkg::ee_addr_t got,
                              eeprom_pkg::ee_addr_t exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_flag(string name, bit got, bit exp);
        if (got !== exp)
            abort_run($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
    endtask

    // unwritten bytes read as erased
    function automatic eeprom_pkg::ee_data_t ref_read(eeprom_pkg::ee_addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : 8'hFF;
    endfunction

    task automatic run_txn(bit is_wr, eeprom_pkg::ee_addr_t a, eeprom_pkg::ee_data_t d);
        int n;
        int extra_at;
        bit extra_wr;
        int stops_before;
        n            = 0;
        extra_at     = int'($urandom_range(3, 60));
        extra_wr     = ($urandom_range(0, 1) == 1);
        stops_before = stop_count;
        wr           = is_wr;
        rd           = !is_wr;
        addr         = a;
        wr_data      = d;
        wait_cycle();
        wr = 1'b0;
        rd = 1'b0;
        check_flag("busy", busy, 1'b1);
        while (!done)
        begin
            n  = n + 1;
            wr = (n == extra_at) && extra_wr;    // stray strobe while busy
            rd = (n == extra_at) && !extra_wr;
            addr    = ~a;
            wr_data = ~d;
            wait_cycle();
        end
        check_flag("busy", busy, 1'b1);
        check_flag("nack", nack, nack_inj);
        check_flag("scl", scl, 1'b1);
        check_flag("sda_oe", sda_oe, 1'b0);
        check_flag("slave in_txn", in_txn, 1'b0);
        if (stop_count != stops_before + 1)
            abort_run("the slave model did not see exactly one stop for the transaction");
        if (!nack_inj)
        begin
            check_data("ctrl_w", ctrl_w, {`EE_DEV_CODE, a[10:8], 1'b0});
            check_addr("addr_seen", addr_seen, a);
            check_flag("rstart_seen", rstart_seen, !is_wr);
            if (is_wr)
            begin
                check_data("data_seen", data_seen, d);
                ref_mem[a] = d;
            end
            else
            begin
                check_data("ctrl_r", ctrl_r, {`EE_DEV_CODE, a[10:8], 1'b1});
                check_flag("mst_nack", mst_nack, 1'b1);
                check_data("rd_data", rd_data, ref_read(a));
            end
        end
        wait_cycle();
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
    endtask

    initial
    begin
        int unsigned          seed;
        bit                   is_wr;
        bit                   recheck;
        eeprom_pkg::ee_addr_t a;
        eeprom_pkg::ee_data_t d;
        seed     = $urandom(19712);
        RESET    = 1'b1;
        wr       = 1'b0;
        rd       = 1'b0;
        addr     = '0;
        wr_data  = '0;
        nack_inj = 1'b0;
        recheck  = 1'b0;
        a        = BASE_ADDR;
        repeat (3) @(posedge CLK);
        #2;
        RESET = 1'b0;
        wait_cycle();
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        check_flag("nack", nack, 1'b0);
        check_flag("scl", scl, 1'b1);
        check_flag("sda_oe", sda_oe, 1'b0);
        for (int i = 0; i < N_TXN; i++)
        begin
            if (recheck)
            begin
                is_wr    = 1'b0;   // read back what the NACKed access left
                nack_inj = 1'b0;
            end
            else
            begin
                is_wr    = ($urandom_range(0, 1) == 1);
                a        = BASE_ADDR + eeprom_pkg::ee_addr_t'($urandom_range(0, 31));
                nack_inj = ($urandom_range(0, 7) == 0);
            end
            recheck = nack_inj;
            d       = eeprom_pkg::ee_data_t'($urandom());
            run_txn(is_wr, a, d);
            repeat ($urandom_range(1, 3))
            begin
                wait_cycle();
                check_flag("done", done, 1'b0);
                check_flag("busy", busy, 1'b0);
            end
        end
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- eeprom_ctrl.f
+incdir+source
source/eeprom_pkg.sv
source/i2c_byte_engine.sv
source/ee_sequencer.sv
source/eeprom_ctrl.sv
dv/ee_slave_model.sv
dv/eeprom_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timescale 1ns/1ps -f eeprom_ctrl.f --top-module eeprom_ctrl_tb \
    -o eeprom_ctrl_sim
out=$(./obj_dir/eeprom_ctrl_sim 2>&1) || true
echo "$out"
if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

//--- source/ee_sequencer.sv
`default_nettype none

`include "eeprom_defines.svh"

module ee_sequencer
(
    input  wire logic                 CLK,
    input  wire logic                 RESET,
    input  wire logic                 wr,
    input  wire logic                 rd,
    input  wire eeprom_pkg::ee_addr_t addr,
    input  wire eeprom_pkg::ee_data_t wr_data,
    output eeprom_pkg::ee_data_t      rd_data,
    output logic                      busy,
    output logic                      done,
    output logic                      nack,
    output logic                      cmd_valid,
    output eeprom_pkg::bit_cmd_e      cmd,
    output eeprom_pkg::ee_data_t      cmd_byte,
    output logic                      cmd_last,
    input  wire logic                 cmd_done,
    input  wire eeprom_pkg::ee_data_t rx_byte,
    input  wire logic                 rx_ack
);

    typedef enum logic [3:0]
    {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA,
        S_RSTART,
        S_CTRL_R,
        S_READ,
        S_STOP,
        S_DONE
    } seq_state_e;

    seq_state_e           state;
    seq_state_e           nxt;
    logic                 op_rd;
    eeprom_pkg::ee_addr_t addr_r;
    eeprom_pkg::ee_data_t data_r;

    assign busy     = (state != S_IDLE);
    assign done     = (state == S_DONE);
    assign cmd_last = (state == S_READ);   // master NACKs the single read byte

    // command follows from the state being served
    always_comb
    begin
        cmd      = eeprom_pkg::CMD_STOP;
        cmd_byte = '0;
        case (state)
            S_START, S_RSTART:
                cmd = eeprom_pkg::CMD_START;
            S_CTRL_W:
            begin
                cmd      = eeprom_pkg::CMD_WRITE;
                cmd_byte = {`EE_DEV_CODE, addr_r[`EE_ADDR_W-1:8], 1'b0};
            end
            S_ADDR:
            begin
                cmd      = eeprom_pkg::CMD_WRITE;
                cmd_byte = addr_r[7:0];
            end
            S_DATA:
            begin
                cmd      = eeprom_pkg::CMD_WRITE;
                cmd_byte = data_r;
            end
            S_CTRL_R:
            begin
                cmd      = eeprom_pkg::CMD_WRITE;
                cmd_byte = {`EE_DEV_CODE, addr_r[`EE_ADDR_W-1:8], 1'b1};
            end
            S_READ:
                cmd = eeprom_pkg::CMD_READ;
            default:
                cmd = eeprom_pkg::CMD_STOP;
        endcase
    end

    always_comb
    begin
        nxt = state;
        case (state)
            S_IDLE:   if (wr || rd) nxt = S_START;
            S_START:  if (cmd_done) nxt = S_CTRL_W;
            S_CTRL_W: if (cmd_done) nxt = rx_ack ? S_ADDR : S_STOP;
            S_ADDR:   if (cmd_done) nxt = !rx_ack ? S_STOP : (op_rd ? S_RSTART : S_DATA);
            S_DATA:   if (cmd_done) nxt = S_STOP;
            S_RSTART: if (cmd_done) nxt = S_CTRL_R;
            S_CTRL_R: if (cmd_done) nxt = rx_ack ? S_READ : S_STOP;
            S_READ:   if (cmd_done) nxt = S_STOP;
            S_STOP:   if (cmd_done) nxt = S_DONE;
            default:  nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            cmd_valid <= 1'b0;
            nack      <= 1'b0;
        end
        else
        begin
            state     <= nxt;
            // one pulse on entry to each bus step
            cmd_valid <= (nxt != state) && (nxt != S_IDLE) && (nxt != S_DONE);
            if (state == S_IDLE && (wr || rd))
                nack <= 1'b0;
            else if (cmd_done && cmd == eeprom_pkg::CMD_WRITE && !rx_ack)
                nack <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && (wr || rd))
        begin
            op_rd  <= !wr;   // wr wins
            addr_r <= addr;
            data_r <= wr_data;
        end
        if (cmd_done && state == S_READ)
            rd_data <= rx_byte;
    end

endmodule

`default_nettype wire

//--- source/eeprom_ctrl.sv
`default_nettype none

module eeprom_ctrl
(
    input  wire logic                 CLK,
    input  wire logic                 RESET,
    input  wire logic                 wr,
    input  wire logic                 rd,
    input  wire eeprom_pkg::ee_addr_t addr,
    input  wire eeprom_pkg::ee_data_t wr_data,
    output eeprom_pkg::ee_data_t      rd_data,
    output logic                      busy,
    output logic                      done,
    output logic                      nack,
    output logic                      scl,
    output logic                      sda_oe,
    input  wire logic                 sda_in
);

    logic                 cmd_valid;
    eeprom_pkg::bit_cmd_e cmd;
    eeprom_pkg::ee_data_t cmd_byte;
    logic                 cmd_last;
    logic                 cmd_done;
    eeprom_pkg::ee_data_t rx_byte;
    logic                 rx_ack;

    ee_sequencer u_seq
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wr_data   (wr_data),
        .rd_data   (rd_data),
        .busy      (busy),
        .done      (done),
        .nack      (nack),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_byte  (cmd_byte),
        .cmd_last  (cmd_last),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .rx_ack    (rx_ack)
    );

    // bit-level bus timing
    i2c_byte_engine u_eng
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_byte  (cmd_byte),
        .cmd_last  (cmd_last),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .rx_ack    (rx_ack),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

endmodule

`default_nettype wire

//--- source/eeprom_defines.svh
`ifndef EEPROM_DEFINES_SVH
`define EEPROM_DEFINES_SVH

// memory geometry of the 24C16 part
`define EE_ADDR_W 11
`define EE_DATA_W 8

// upper nibble of the control byte
`define EE_DEV_CODE 4'b1010

// CLK cycles per quarter of an SCL period
`define SCL_QTR 2

`endif

//--- source/eeprom_pkg.sv
`default_nettype none

`include "eeprom_defines.svh"

package eeprom_pkg;

    typedef logic [`EE_ADDR_W-1:0] ee_addr_t;
    typedef logic [`EE_DATA_W-1:0] ee_data_t;

    // one bus-level operation for the byte engine
    typedef enum logic [1:0]
    {
        CMD_START = 2'd0,
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2,
        CMD_READ  = 2'd3
    } bit_cmd_e;

endpackage

`default_nettype wire

//--- source/i2c_byte_engine.sv
`default_nettype none

`include "eeprom_defines.svh"

module i2c_byte_engine
(
    input  wire logic                 CLK,
    input  wire logic                 RESET,
    input  wire logic                 cmd_valid,
    input  wire eeprom_pkg::bit_cmd_e cmd,
    input  wire eeprom_pkg::ee_data_t cmd_byte,
    input  wire logic                 cmd_last,
    output logic                      cmd_done,
    output eeprom_pkg::ee_data_t      rx_byte,
    output logic                      rx_ack,
    output logic                      scl,
    output logic                      sda_oe,
    input  wire logic                 sda_in
);

    localparam int QW = $clog2(`SCL_QTR + 1);

    logic                 active;
    logic [1:0]           phase;    // quarter within the bit
    logic [QW-1:0]        qcnt;
    logic [3:0]           bitcnt;   // 0..7 data, 8 is the ack bit
    eeprom_pkg::bit_cmd_e cmd_r;
    eeprom_pkg::ee_data_t sh;
    logic                 last_r;
    logic                 qend;
    logic                 bit_last;

    assign qend = (qcnt == QW'(`SCL_QTR - 1));

    // start and stop are a single bit time
    assign bit_last = (cmd_r == eeprom_pkg::CMD_START) ||
                      (cmd_r == eeprom_pkg::CMD_STOP) ||
                      (bitcnt == 4'd8);

    assign cmd_done = active && qend && (phase == 2'd3) && bit_last;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active <= 1'b0;
            phase  <= 2'd0;
            qcnt   <= '0;
            bitcnt <= 4'd0;
            scl    <= 1'b1;
            sda_oe <= 1'b0;
            rx_ack <= 1'b0;
        end
        else if (!active)
        begin
            if (cmd_valid)
            begin
                active <= 1'b1;
                phase  <= 2'd0;
                qcnt   <= '0;
                bitcnt <= 4'd0;
                scl    <= 1'b0;
                // first quarter, SCL low, set up SDA
                case (cmd)
                    eeprom_pkg::CMD_START: sda_oe <= 1'b0;
                    eeprom_pkg::CMD_STOP:  sda_oe <= 1'b1;
                    eeprom_pkg::CMD_WRITE: sda_oe <= ~cmd_byte[7];
                    default:               sda_oe <= 1'b0;
                endcase
            end
        end
        else if (!qend)
        begin
            qcnt <= qcnt + 1'b1;
        end
        else
        begin
            qcnt  <= '0;
            phase <= phase + 2'd1;
            case (phase)
                2'd0:
                begin
                    scl <= 1'b1;
                end
                2'd1:
                begin
                    // middle of SCL high
                    if (cmd_r == eeprom_pkg::CMD_START)
                        sda_oe <= 1'b1;
                    else if (cmd_r == eeprom_pkg::CMD_STOP)
                        sda_oe <= 1'b0;
                    else if (cmd_r == eeprom_pkg::CMD_WRITE && bitcnt == 4'd8)
                        rx_ack <= ~sda_in;   // slave pulled low
                end
                2'd2:
                begin
                    if (cmd_r != eeprom_pkg::CMD_STOP)
                        scl <= 1'b0;         // bus stays idle after a stop
                end
                default:
                begin
                    if (bit_last)
                    begin
                        active <= 1'b0;
                    end
                    else
                    begin
                        bitcnt <= bitcnt + 4'd1;
                        if (bitcnt == 4'd7)
                            sda_oe <= (cmd_r == eeprom_pkg::CMD_READ) ? ~last_r : 1'b0;
                        else
                            sda_oe <= (cmd_r == eeprom_pkg::CMD_WRITE) ? ~sh[6] : 1'b0;
                    end
                end
            endcase
        end
    end

    // command payload and shift registers
    always_ff @(posedge CLK)
    begin
        if (!active && cmd_valid)
        begin
            cmd_r  <= cmd;
            sh     <= cmd_byte;
            last_r <= cmd_last;
        end
        else if (active && qend)
        begin
            if (phase == 2'd1 && cmd_r == eeprom_pkg::CMD_READ && bitcnt < 4'd8)
                rx_byte <= {rx_byte[6:0], sda_in};   // msb first
            if (phase == 2'd3)
                sh <= {sh[6:0], 1'b0};
        end
    end

endmodule

`default_nettype wire
